/* source/dcache_pkg.sv */
// data cache package
// geometry, address fields and shared types
`default_nettype none

package dcache_pkg;

  localparam int num_ways  = 4;
  localparam int num_sets  = 256;
  localparam int addr_w    = 20;    // byte address, 1MB space
  localparam int tag_w     = 10;
  localparam int index_w   = 8;
  localparam int offset_w  = 2;
  localparam int word_w    = 32;
  localparam int age_w     = 2;     // lru counter per way
  localparam int num_lanes = word_w / 8;

  typedef logic [addr_w-1:0]           addr_t;
  typedef logic [index_w-1:0]          index_t;
  typedef logic [tag_w-1:0]            ctag_t;
  typedef logic [offset_w-1:0]         offset_t;
  typedef logic [word_w-1:0]           word_t;
  typedef logic [$clog2(num_ways)-1:0] way_t;
  typedef logic [age_w-1:0]            age_t;   // 0 = most recently used

  typedef struct packed {
    logic  valid;
    age_t  age;
    ctag_t tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_illegal   // no lanes written
  } store_size_e;

  // what the writers commit this cycle
  typedef enum logic [1:0] {
    acc_read,
    acc_store,
    acc_fill,
    acc_init
  } access_kind_e;

  function automatic ctag_t get_tag(input addr_t a);
    return a[addr_w-1 -: tag_w];   // bits 19..10
  endfunction

  function automatic index_t get_index(input addr_t a);
    return a[offset_w +: index_w];   // bits 9..2
  endfunction

  function automatic offset_t get_offset(input addr_t a);
    return a[offset_w-1:0];   // byte lane
  endfunction

endpackage

`default_nettype wire

/* source/dcache_ifs.sv */
// tag and data array ports
`timescale 1ns/100ps
`default_nettype none

interface tag_port_if import dcache_pkg::*; ();

  index_t     rd_index;            // sampled on the clock edge
  index_t     wr_index;
  logic       we;                  // one enable, all ways written together
  tag_entry_t wdata [num_ways];
  tag_entry_t rdata [num_ways];    // one cycle after rd_index

  modport ctrl   (output rd_index, output wr_index);
  modport writer (output we, output wdata, input rdata);
  modport reader (input rdata);
  modport array  (input rd_index, input wr_index, input we, input wdata, output rdata);

endinterface

interface data_port_if import dcache_pkg::*; ();

  index_t              rd_index;
  index_t              wr_index;
  logic [num_ways-1:0] we;            // per way
  word_t               wdata;         // shared by all ways
  word_t               rdata [num_ways];

  modport ctrl   (output rd_index, output wr_index);
  modport writer (output we, output wdata, input rdata);
  modport array  (input rd_index, input wr_index, input we, input wdata, output rdata);

endinterface

`default_nettype wire

/* source/sync_ram.sv */
// registered-read RAM
`timescale 1ns/100ps
`default_nettype none

module sync_ram import dcache_pkg::*; #(
  parameter type payload_t = word_t,
  parameter int  depth     = num_sets
) (
  input  wire logic     CLK,
  input  wire index_t   rd_index,
  input  wire logic     we,
  input  wire index_t   wr_index,
  input  wire payload_t wdata,
  output payload_t      rdata
);

  payload_t mem [depth];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[wr_index] <= wdata;
    end
    rdata <= mem[rd_index];   // old data on same-address write
  end

endmodule

`default_nettype wire

/* source/dcache_ctrl.sv */
// cache request FSM
// address latch, init sweep, array indexing
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
  input  wire logic    CLK,
  input  wire logic    resetn,
  input  wire logic    read_en,
  input  wire logic    write_en,
  input  wire logic    fetch,
  input  wire addr_t   addr,
  input  wire logic    lookup_ok,
  output logic         cache_miss,
  output logic         write_ready,
  output logic         upd_en,
  output access_kind_e kind,
  output addr_t        req_addr,
  output logic         fill_for_read,
  tag_port_if.ctrl     tag_port,
  data_port_if.ctrl    data_port
);

  typedef enum logic [2:0] {s_init, s_idle, s_read, s_store, s_fill} state_e;

  state_e state;
  state_e state_nxt;
  index_t init_cnt;
  logic   pend_read;
  logic   req_take;
  index_t rd_index;
  index_t wr_index;

  assign req_take = (state == s_idle) && (read_en || write_en);   // ignored outside idle

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= s_init;
      init_cnt  <= '0;
      pend_read <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == s_init) begin
        init_cnt <= init_cnt + 1'b1;   // wraps to 0 on leaving init
      end
      if (req_take) begin
        pend_read <= read_en;   // read wins if both pulse
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (req_take) begin
      req_addr <= addr;
    end
  end

  always_comb begin
    state_nxt   = state;
    upd_en      = 1'b0;
    kind        = acc_read;
    cache_miss  = 1'b0;
    write_ready = 1'b0;
    case (state)
      s_init: begin
        upd_en = 1'b1;   // one set per cycle
        kind   = acc_init;
        if (init_cnt == index_t'(num_sets - 1)) begin
          state_nxt = s_idle;
        end
      end
      s_idle: begin
        if (read_en) begin
          state_nxt = s_read;
        end else if (write_en) begin
          state_nxt = s_store;
        end
      end
      s_read: begin
        if (lookup_ok) begin
          upd_en    = 1'b1;   // hit, age update
          state_nxt = s_idle;
        end else begin
          cache_miss = 1'b1;
          state_nxt  = s_fill;
        end
      end
      s_store: begin
        kind = acc_store;
        if (lookup_ok) begin
          upd_en      = 1'b1;
          write_ready = 1'b1;
          state_nxt   = s_idle;
        end else begin
          cache_miss = 1'b1;   // set full, no match
          state_nxt  = s_fill;
        end
      end
      s_fill: begin
        kind = acc_fill;
        if (fetch) begin
          upd_en    = 1'b1;   // victim written this cycle
          state_nxt = s_idle;
        end else begin
          cache_miss = 1'b1;   // held until fetch
        end
      end
      default: state_nxt = s_init;
    endcase
  end

  assign fill_for_read = pend_read;

  // idle follows the bus so the result lands one cycle after the request
  assign rd_index = (state == s_idle) ? get_index(addr) : get_index(req_addr);
  assign wr_index = (state == s_init) ? init_cnt : get_index(req_addr);

  assign tag_port.rd_index  = rd_index;
  assign tag_port.wr_index  = wr_index;
  assign data_port.rd_index = rd_index;
  assign data_port.wr_index = wr_index;

endmodule

`default_nettype wire

/* source/dcache_way_select.sv */
// way select: hit, free way, victim
`timescale 1ns/100ps
`default_nettype none

module dcache_way_select import dcache_pkg::*; (
  input  wire access_kind_e kind,
  input  wire addr_t        req_addr,
  tag_port_if.reader        tag_port,
  output logic              lookup_ok,
  output way_t              access_way
);

  logic [num_ways-1:0] hit_vec;
  logic [num_ways-1:0] free_vec;
  way_t                old_way;

  // lowest-numbered way with its bit set
  function automatic way_t lowest_set(input logic [num_ways-1:0] vec);
    way_t sel;
    sel = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (vec[w]) sel = way_t'(w);
    end
    return sel;
  endfunction

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w]  = tag_port.rdata[w].valid && (tag_port.rdata[w].tag == get_tag(req_addr));
      free_vec[w] = !tag_port.rdata[w].valid;
    end
  end

  always_comb begin
    old_way = '0;
    for (int w = 1; w < num_ways; w++) begin
      if (tag_port.rdata[w].age > tag_port.rdata[old_way].age) begin
        old_way = way_t'(w);   // strict, ties keep lower way
      end
    end
  end

  always_comb begin
    lookup_ok  = 1'b0;
    access_way = '0;
    case (kind)
      acc_read: begin
        lookup_ok  = |hit_vec;
        access_way = lowest_set(hit_vec);
      end
      acc_store: begin
        lookup_ok  = |hit_vec || |free_vec;   // miss only on full set
        access_way = |hit_vec ? lowest_set(hit_vec) : lowest_set(free_vec);
      end
      acc_fill: begin
        lookup_ok  = 1'b1;   // a victim always exists
        access_way = |free_vec ? lowest_set(free_vec) : old_way;
      end
      default: begin
        lookup_ok  = 1'b0;
        access_way = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/dcache_tag_update.sv */
// tag entry update, lru ages
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_update import dcache_pkg::*; (
  input  wire logic         upd_en,
  input  wire access_kind_e kind,
  input  wire addr_t        req_addr,
  input  wire way_t         access_way,
  tag_port_if.writer        tag_port
);

  age_t old_age;

  assign tag_port.we = upd_en;

  always_comb begin
    old_age = tag_port.rdata[access_way].age;   // accessed way before update
    for (int w = 0; w < num_ways; w++) begin
      tag_port.wdata[w] = tag_port.rdata[w];
      if (kind == acc_init) begin
        tag_port.wdata[w].valid = 1'b0;
        tag_port.wdata[w].age   = age_t'(w);   // ages start as a permutation
        tag_port.wdata[w].tag   = '0;
      end else if (way_t'(w) == access_way) begin
        tag_port.wdata[w].valid = 1'b1;
        tag_port.wdata[w].age   = '0;   // now most recent
        tag_port.wdata[w].tag   = get_tag(req_addr);
      end else if (tag_port.rdata[w].age < old_age) begin
        tag_port.wdata[w].age = tag_port.rdata[w].age + 1'b1;   // younger ways age by one
      end
    end
  end

endmodule

`default_nettype wire

/* source/dcache_data_path.sv */
// data array writes and read data
`timescale 1ns/100ps
`default_nettype none

module dcache_data_path import dcache_pkg::*; (
  input  wire logic         upd_en,
  input  wire access_kind_e kind,
  input  wire addr_t        req_addr,
  input  wire way_t         access_way,
  input  wire word_t        cpu_wdata,    // already in its lane
  input  wire word_t        fill_wdata,
  input  wire store_size_e  store_size,   // held by requester into result cycle
  input  wire logic         fill_for_read,
  data_port_if.writer       data_port,
  output logic              rdata_valid,
  output word_t             rdata
);

  typedef logic [num_lanes-1:0] lane_mask_t;

  lane_mask_t lane_mask;
  offset_t    offset;
  word_t      cur_word;
  word_t      merged;

  assign offset   = get_offset(req_addr);
  assign cur_word = data_port.rdata[access_way];

  always_comb begin
    case (store_size)
      size_byte: lane_mask = lane_mask_t'(1) << offset;
      size_half: lane_mask = offset[1] ? 4'b1100 : 4'b0011;   // aligned halves only
      size_word: lane_mask = '1;
      default:   lane_mask = '0;   // illegal size, word unchanged
    endcase
  end

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      merged[8*l +: 8] = lane_mask[l] ? cpu_wdata[8*l +: 8] : cur_word[8*l +: 8];
    end
  end

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      data_port.we[w] = upd_en && (kind == acc_store || kind == acc_fill)
                        && (access_way == way_t'(w));
    end
  end

  assign data_port.wdata = (kind == acc_fill) ? fill_wdata : merged;

  assign rdata       = (kind == acc_fill) ? fill_wdata : cur_word;   // fill word passes through
  assign rdata_valid = upd_en && ((kind == acc_read) || (kind == acc_fill && fill_for_read));

endmodule

`default_nettype wire

/* source/dcache_top.sv */
// 4-way set-associative data cache
`timescale 1ns/100ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  wire logic        CLK,
  input  wire logic        resetn,
  input  wire logic        read_en,
  input  wire logic        write_en,
  input  wire logic        fetch,
  input  wire addr_t       addr,
  input  wire word_t       cpu_wdata,
  input  wire word_t       fill_wdata,
  input  wire store_size_e store_size,
  output logic             cache_miss,
  output logic             rdata_valid,
  output logic             write_ready,
  output word_t            rdata
);

  logic         upd_en;
  access_kind_e kind;
  addr_t        req_addr;
  logic         fill_for_read;
  logic         lookup_ok;
  way_t         access_way;

  tag_port_if  tag_port ();
  data_port_if data_port ();

  dcache_ctrl i_ctrl (
    .CLK, .resetn, .read_en, .write_en, .fetch, .addr, .lookup_ok,
    .cache_miss, .write_ready, .upd_en, .kind, .req_addr, .fill_for_read,
    .tag_port(tag_port), .data_port(data_port)
  );

  dcache_way_select i_way_select (
    .kind, .req_addr, .tag_port(tag_port), .lookup_ok, .access_way
  );

  dcache_tag_update i_tag_update (
    .upd_en, .kind, .req_addr, .access_way, .tag_port(tag_port)
  );

  dcache_data_path i_data_path (
    .upd_en, .kind, .req_addr, .access_way, .cpu_wdata, .fill_wdata, .store_size,
    .fill_for_read, .data_port(data_port), .rdata_valid, .rdata
  );

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    sync_ram #(.payload_t(tag_entry_t)) i_tag_ram (
      .CLK, .rd_index(tag_port.rd_index), .we(tag_port.we), .wr_index(tag_port.wr_index),
      .wdata(tag_port.wdata[w]), .rdata(tag_port.rdata[w])
    );
    sync_ram #(.payload_t(word_t)) i_data_ram (
      .CLK, .rd_index(data_port.rd_index), .we(data_port.we[w]),
      .wr_index(data_port.wr_index), .wdata(data_port.wdata), .rdata(data_port.rdata[w])
    );
  end

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
// data cache testbench
// stimulus table, reference model, watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

  localparam int    clk_period   = 40;
  localparam int    reset_cycles = 3;
  localparam int    init_margin  = 4;    // idle cycles after the sweep
  localparam int    tab_len      = 96;   // table capacity
  localparam word_t seed         = 32'd46;

  typedef enum logic [1:0] {op_read, op_store, op_fetch} op_e;

  typedef struct packed {
    op_e         op;
    addr_t       addr;
    word_t       data;        // store word or fill word
    store_size_e size;
    logic        exp_miss;
    logic        exp_valid;   // rdata_valid expected
    word_t       exp_word;
  } entry_t;

  logic        CLK;
  logic        resetn;
  logic        read_en;
  logic        write_en;
  logic        fetch;
  addr_t       addr;
  word_t       cpu_wdata;
  word_t       fill_wdata;
  store_size_e store_size;
  logic        cache_miss;
  logic        rdata_valid;
  logic        write_ready;
  word_t       rdata;

  entry_t tab [tab_len];
  string  tab_name [tab_len];
  int     tab_count;
  logic   table_built;
  word_t  rng_state;

  // reference model of the arrays
  logic  m_valid [num_sets][num_ways];
  ctag_t m_tag   [num_sets][num_ways];
  age_t  m_age   [num_sets][num_ways];
  word_t m_data  [num_sets][num_ways];   // never read before written
  logic  m_pend_read;                    // miss waiting for a fill
  addr_t m_pend_addr;
  ctag_t m_evict_tag;                    // tag replaced by the last fill

  dcache_top i_dut (
    .CLK, .resetn, .read_en, .write_en, .fetch, .addr, .cpu_wdata, .fill_wdata,
    .store_size, .cache_miss, .rdata_valid, .write_ready, .rdata
  );

  always #(clk_period/2) CLK = ~CLK;

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t make_addr(input int t, input int s, input int off);
    return addr_t'({ctag_t'(t), index_t'(s), offset_t'(off)});
  endfunction

  function automatic ctag_t tag_of(input addr_t a);
    return a[addr_w-1:addr_w-tag_w];   // upper 10 bits
  endfunction

  function automatic int set_of(input addr_t a);
    return int'(a[offset_w+index_w-1:offset_w]);
  endfunction

  function automatic int find_hit(input addr_t a);
    for (int w = 0; w < num_ways; w++) begin
      if (m_valid[set_of(a)][w] && m_tag[set_of(a)][w] == tag_of(a)) return w;
    end
    return -1;
  endfunction

  function automatic int find_free(input int s);
    for (int w = 0; w < num_ways; w++) begin
      if (!m_valid[s][w]) return w;   // lowest invalid way
    end
    return -1;
  endfunction

  function automatic int find_victim(input int s);
    int v;
    v = find_free(s);
    if (v < 0) begin
      v = 0;
      for (int w = 1; w < num_ways; w++) begin
        if (m_age[s][w] > m_age[s][v]) v = w;   // first way of the highest age
      end
    end
    return v;
  endfunction

  function automatic logic [num_lanes-1:0] lane_mask(input store_size_e sz, input offset_t off);
    logic [num_lanes-1:0] m;
    case (sz)
      size_byte: m = 4'b0001 << off;
      size_half: m = off[1] ? 4'b1100 : 4'b0011;
      size_word: m = 4'b1111;
      default:   m = 4'b0000;   // illegal size writes nothing
    endcase
    return m;
  endfunction

  function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                        input logic [num_lanes-1:0] mask);
    word_t r;
    r = old_w;
    for (int l = 0; l < num_lanes; l++) begin
      if (mask[l]) r[8*l +: 8] = new_w[8*l +: 8];
    end
    return r;
  endfunction

  task automatic model_reset();
    for (int s = 0; s < num_sets; s++) begin
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_age[s][w]   = age_t'(w);   // sweep leaves age = way number
        m_data[s][w]  = '0;
      end
    end
  endtask

  // make a way the most recent, younger ways age by one
  task automatic model_touch(input addr_t a, input int way);
    int   s;
    age_t old;
    s   = set_of(a);
    old = m_age[s][way];
    for (int w = 0; w < num_ways; w++) begin
      if (w != way && m_age[s][w] < old) m_age[s][w] = m_age[s][w] + 1'b1;
    end
    m_age[s][way]   = '0;
    m_valid[s][way] = 1'b1;
    m_tag[s][way]   = tag_of(a);
  endtask

  task automatic push_entry(input entry_t e, input string name);
    if (tab_count >= tab_len) begin
      $display("stimulus table is full at test %s", name);
      $display("sim failed");
      $fatal(1, "table overflow");
    end
    tab[tab_count]      = e;
    tab_name[tab_count] = name;
    tab_count++;
  endtask

  task automatic add_fetch(input string name);
    entry_t e;
    int     s;
    int     way;
    e             = '0;
    e.op          = op_fetch;
    e.data        = next_word();
    s             = set_of(m_pend_addr);
    way           = find_victim(s);
    m_evict_tag   = m_tag[s][way];
    m_data[s][way] = e.data;
    model_touch(m_pend_addr, way);
    e.exp_valid   = m_pend_read;   // store fills return nothing
    e.exp_word    = e.data;
    push_entry(e, name);
  endtask

  task automatic add_read(input string name, input addr_t a);
    entry_t e;
    int     way;
    e      = '0;
    e.op   = op_read;
    e.addr = a;
    e.size = size_word;
    way    = find_hit(a);
    if (way >= 0) begin
      e.exp_valid = 1'b1;
      e.exp_word  = m_data[set_of(a)][way];
      model_touch(a, way);
    end else begin
      e.exp_miss  = 1'b1;
      m_pend_read = 1'b1;
      m_pend_addr = a;
    end
    push_entry(e, name);
    if (e.exp_miss) add_fetch(name);   // every miss is followed by its fill
  endtask

  task automatic add_store(input string name, input addr_t a, input store_size_e sz,
                           input word_t d);
    entry_t e;
    int     s;
    int     way;
    e      = '0;
    e.op   = op_store;
    e.addr = a;
    e.data = d;
    e.size = sz;
    s      = set_of(a);
    way    = find_hit(a);
    if (way < 0) way = find_free(s);
    if (way >= 0) begin
      m_data[s][way] = merge_lanes(m_data[s][way], d, lane_mask(sz, a[offset_w-1:0]));
      model_touch(a, way);
    end else begin
      e.exp_miss  = 1'b1;   // full set, no match
      m_pend_read = 1'b0;
      m_pend_addr = a;
    end
    push_entry(e, name);
    if (e.exp_miss) add_fetch(name);
  endtask

  task automatic build_table();
    addr_t a;
    word_t d;
    word_t r;
    int    ev;
    rng_state = seed;
    tab_count = 0;
    model_reset();
    add_read("read_miss_fill", make_addr(1, 5, 0));
    add_read("read_hit", make_addr(1, 5, 0));
    a = make_addr(2, 9, 0);
    add_store("store_word", a, size_word, next_word());   // free way
    add_read("store_word", a);
    for (int off = 0; off < num_lanes; off++) begin
      add_store("store_byte", make_addr(2, 9, off), size_byte, next_word());
      add_read("store_byte", a);
    end
    for (int off = 0; off < num_lanes; off += 2) begin
      add_store("store_half", make_addr(2, 9, off), size_half, next_word());
      add_read("store_half", a);
    end
    add_store("store_illegal", make_addr(2, 9, 3), size_illegal, next_word());
    add_read("store_illegal", a);
    add_store("store_match", make_addr(1, 5, 1), size_byte, next_word());
    add_read("store_match", make_addr(1, 5, 0));
    for (int t = 3; t <= 6; t++) add_read("full_set_fill", make_addr(t, 20, 0));
    d = next_word();
    add_store("store_full_miss", make_addr(7, 20, 2), size_half, d);
    add_store("store_reissue", make_addr(7, 20, 2), size_half, d);
    add_read("store_reissue", make_addr(7, 20, 0));
    for (int t = 10; t <= 13; t++) add_read("lru_fill", make_addr(t, 33, 0));
    add_read("lru_touch", make_addr(10, 33, 0));
    add_read("lru_touch", make_addr(12, 33, 0));
    add_read("lru_new_tag", make_addr(14, 33, 0));
    ev = int'(m_evict_tag);   // oldest way's tag
    for (int t = 10; t <= 13; t++) begin
      if (t != ev) add_read("lru_kept", make_addr(t, 33, 0));
    end
    add_read("lru_evicted", make_addr(ev, 33, 0));
    for (int i = 0; i < 16; i++) begin
      r = next_word();
      a = make_addr(int'(r[2:0]), 40 + int'(r[3]), int'(r[5:4]));
      if (r[6] && find_hit(a) >= 0) begin
        add_store("random_store", a, store_size_e'(r[8:7]), next_word());
      end else if (r[6]) begin
        add_store("random_store", a, size_word, next_word());   // free or full set
      end else begin
        add_read("random_read", a);
      end
    end
  endtask

  task automatic check_flag(input string name, input string sig, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %b, actual %b", name, sig, exp, act);
      $display("sim failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAIL %s rdata: expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_quiet(input string name);
    check_flag(name, "cache_miss", 1'b0, cache_miss);
    check_flag(name, "rdata_valid", 1'b0, rdata_valid);
    check_flag(name, "write_ready", 1'b0, write_ready);
  endtask

  task automatic apply_entry(input int i);
    entry_t e;
    string  n;
    e = tab[i];
    n = tab_name[i];
    @(negedge CLK);
    fetch = 1'b0;
    if (e.op == op_fetch) begin
      #(clk_period/4);
      check_flag(n, "cache_miss held", 1'b1, cache_miss);   // one wait cycle in fill
      check_flag(n, "rdata_valid held", 1'b0, rdata_valid);
      @(negedge CLK);
      fetch      = 1'b1;
      fill_wdata = e.data;
      #(clk_period/4);
      check_flag(n, "cache_miss", 1'b0, cache_miss);
      check_flag(n, "rdata_valid", e.exp_valid, rdata_valid);
      check_flag(n, "write_ready", 1'b0, write_ready);
      if (e.exp_valid) check_word(n, e.exp_word, rdata);
    end else begin
      addr       = e.addr;
      cpu_wdata  = e.data;
      store_size = e.size;   // held into the result cycle
      read_en    = (e.op == op_read);
      write_en   = (e.op == op_store);
      #(clk_period/4);
      check_quiet(n);
      @(negedge CLK);
      read_en  = 1'b0;
      write_en = 1'b0;
      #(clk_period/4);
      check_flag(n, "cache_miss", e.exp_miss, cache_miss);
      check_flag(n, "rdata_valid", e.exp_valid, rdata_valid);
      check_flag(n, "write_ready", e.op == op_store && !e.exp_miss, write_ready);
      if (e.exp_valid) check_word(n, e.exp_word, rdata);
    end
  endtask

  initial begin
    int timeout_cycles;
    wait (table_built === 1'b1);
    timeout_cycles = reset_cycles + num_sets + init_margin + tab_count * 8;
    #(timeout_cycles * clk_period);
    $display("run timed out after %0d cycles", timeout_cycles);
    $display("sim failed");
    $fatal(1, "watchdog");
  end

  initial begin
    CLK         = 1'b0;
    resetn      = 1'b0;
    read_en     = 1'b0;
    write_en    = 1'b0;
    fetch       = 1'b0;
    addr        = '0;
    cpu_wdata   = '0;
    fill_wdata  = '0;
    store_size  = size_word;
    table_built = 1'b0;
    build_table();
    table_built = 1'b1;
    for (int c = 0; c < reset_cycles; c++) begin
      @(negedge CLK);
      if (c == reset_cycles - 1) resetn = 1'b1;
      #(clk_period/4);
      check_quiet("reset");
    end
    for (int c = 0; c < num_sets + init_margin; c++) begin
      @(negedge CLK);
      #(clk_period/4);
      check_quiet("init");   // sweep runs num_sets cycles
    end
    for (int i = 0; i < tab_count; i++) begin
      apply_entry(i);
    end
    @(negedge CLK);
    fetch = 1'b0;
    #(clk_period/4);
    check_quiet("end");
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
source/dcache_pkg.sv
source/dcache_ifs.sv
source/sync_ram.sv
source/dcache_ctrl.sv
source/dcache_way_select.sv
source/dcache_tag_update.sv
source/dcache_data_path.sv
source/dcache_top.sv
sim/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_dcache -o tb_dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_dcache_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
